//--- hdl/mdu_macros.svh
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

// --------------------
// issue queue sizing
// --------------------

// number of queue entries, power of two
`define IQ_SIZE 8

// head and tail pointer width
`define IQ_PTR_LEN 3

// --------------------
// operands and wakeup
// --------------------

// source operands per micro-op
`define SRC_COUNT 2

// common data bus broadcast ports
`define CDB_COUNT 2

`endif

//--- hdl/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

    // data word and ROB tag
    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_id_t;

    // --------------------
    // operand slot
    // --------------------

    // present means value holds real data, otherwise wait on tag
    typedef struct packed {
        logic    present;
        rob_id_t tag;
        word_t   value;
    } operand_t;

    // one CDB broadcast port
    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

endpackage

`default_nettype wire

//--- hdl/mdu_pkg.sv
`default_nettype none

`include "mdu_macros.svh"

package mdu_pkg;

    // low word, signed high word, unsigned high word
    typedef enum logic [1:0] {
        MUL_W   = 2'd0,
        MULH_W  = 2'd1,
        MULH_WU = 2'd2
    } mul_op_e;

    // --------------------
    // queue side
    // --------------------

    // one dispatch slot, also the stored entry contents
    typedef struct packed {
        mul_op_e                                    op;
        cpu_types_pkg::rob_id_t                     dest;
        cpu_types_pkg::operand_t [`SRC_COUNT-1:0]   src;
    } dispatch_t;

    // --------------------
    // multiplier side
    // --------------------

    typedef struct packed {
        mul_op_e                                op;
        cpu_types_pkg::rob_id_t                 dest;
        cpu_types_pkg::word_t [`SRC_COUNT-1:0]  data;
    } mul_req_t;

    typedef struct packed {
        cpu_types_pkg::rob_id_t dest;
        cpu_types_pkg::word_t   data;
    } mul_res_t;

endpackage

`default_nettype wire

//--- hdl/iq_alloc.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_macros.svh"

module iq_alloc (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n_i,
    input  wire logic                                   flush_i,
    input  wire logic [1:0]                             choose_i,
    input  wire mdu_pkg::dispatch_t [1:0]               dispatch_i,
    input  wire logic                                   issue_i,
    output logic                                        entry_ready_o,
    output logic [`IQ_SIZE-1:0]                         wr_en_o,
    output mdu_pkg::dispatch_t [`IQ_SIZE-1:0]           wr_data_o
);

    localparam int PTR_W  = `IQ_PTR_LEN;
    localparam int FREE_W = `IQ_PTR_LEN + 1;

    logic [1:0]         take;
    logic [1:0]         take_cnt;
    logic [PTR_W-1:0]   tail_q;
    logic [PTR_W-1:0]   tail_p1;
    logic [PTR_W-1:0]   tail_d;
    logic [FREE_W-1:0]  free_q;
    logic [FREE_W-1:0]  free_d;
    mdu_pkg::dispatch_t first_slot;

    // choose bits only count while the queue said it had room
    assign take     = choose_i & {2{entry_ready_o}};
    assign take_cnt = {1'b0, take[0]} + {1'b0, take[1]};

    assign tail_p1 = tail_q + 1'b1;
    assign tail_d  = tail_q + PTR_W'(take_cnt);
    assign free_d  = free_q - FREE_W'(take_cnt) + FREE_W'(issue_i);

    // a lone slot 1 still lands at the tail
    assign first_slot = take[0] ? dispatch_i[0] : dispatch_i[1];

    // --------------------
    // write steering
    // --------------------
    for (genvar i = 0; i < `IQ_SIZE; i++) begin : g_steer
        assign wr_en_o[i] = ((take != 2'b00) && (tail_q == PTR_W'(i))) ||
                            ((&take) && (tail_p1 == PTR_W'(i)));
        assign wr_data_o[i] = ((&take) && (tail_p1 == PTR_W'(i))) ? dispatch_i[1]
                                                                   : first_slot;
    end

    // --------------------
    // tail and free count
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            tail_q        <= '0;
            free_q        <= FREE_W'(`IQ_SIZE);
            entry_ready_o <= 1'b1;
        end else begin
            tail_q        <= tail_d;
            free_q        <= free_d;
            // room for a full dual dispatch next cycle
            entry_ready_o <= (free_d >= FREE_W'(2));
        end
    end

endmodule

`default_nettype wire

//--- hdl/iq_entry.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_macros.svh"

module iq_entry (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n_i,
    input  wire logic                                       flush_i,
    input  wire logic                                       wr_en_i,
    input  wire mdu_pkg::dispatch_t                         wr_data_i,
    input  wire cpu_types_pkg::cdb_t [`CDB_COUNT-1:0]       cdb_i,
    input  wire logic                                       clear_i,
    output logic                                            ready_o,
    output mdu_pkg::dispatch_t                              entry_o
);

    logic               valid_q;
    mdu_pkg::dispatch_t entry_q;
    mdu_pkg::dispatch_t entry_d;

    // --------------------
    // operand wakeup
    // --------------------

    // new op or held op, then merge any CDB hit into absent operands
    always_comb begin
        entry_d = wr_en_i ? wr_data_i : entry_q;
        for (int s = 0; s < `SRC_COUNT; s++) begin
            for (int c = 0; c < `CDB_COUNT; c++) begin
                if (!entry_d.src[s].present && cdb_i[c].valid &&
                    (cdb_i[c].tag == entry_d.src[s].tag)) begin
                    entry_d.src[s].present = 1'b1;
                    entry_d.src[s].value   = cdb_i[c].data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        entry_q <= entry_d;
    end

    // --------------------
    // valid bit
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (wr_en_i) begin
            valid_q <= 1'b1;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end
    end

    // ready only from registered operands
    always_comb begin
        ready_o = valid_q;
        for (int s = 0; s < `SRC_COUNT; s++) begin
            ready_o = ready_o & entry_q.src[s].present;
        end
    end

    assign entry_o = entry_q;

endmodule

`default_nettype wire

//--- hdl/iq_issue.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_macros.svh"

module iq_issue (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n_i,
    input  wire logic                                   flush_i,
    input  wire logic [`IQ_SIZE-1:0]                    ready_i,
    input  wire mdu_pkg::dispatch_t [`IQ_SIZE-1:0]      entry_i,
    input  wire logic                                   accept_i,
    output logic [`IQ_SIZE-1:0]                         clear_o,
    output logic                                        issue_o,
    output mdu_pkg::mul_req_t                           req_o,
    output logic                                        req_valid_o
);

    localparam int PTR_W = `IQ_PTR_LEN;
    localparam int SIZE  = `IQ_SIZE;

    logic [PTR_W-1:0]   head_q;
    logic               fire;
    mdu_pkg::dispatch_t head_entry;
    mdu_pkg::mul_req_t  req_d;

    // strictly in order, only the head may go
    assign head_entry = entry_i[head_q];
    assign fire       = ready_i[head_q] & accept_i;
    assign issue_o    = fire;
    assign clear_o    = fire ? (SIZE'(1) << head_q) : '0;

    // strip tags, keep only operand values
    always_comb begin
        req_d.op   = head_entry.op;
        req_d.dest = head_entry.dest;
        for (int s = 0; s < `SRC_COUNT; s++) begin
            req_d.data[s] = head_entry.src[s].value;
        end
    end

    // --------------------
    // head and request regs
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q      <= '0;
            req_valid_o <= 1'b0;
        end else begin
            if (fire) begin
                head_q <= head_q + 1'b1;
            end
            // hold the request while the multiplier is stalled
            if (accept_i) begin
                req_valid_o <= fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            req_o <= req_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mul_unit (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   flush_i,
    input  wire mdu_pkg::mul_req_t      req_i,
    input  wire logic                   req_valid_i,
    output logic                        accept_o,
    output mdu_pkg::mul_res_t           res_o,
    output logic                        res_valid_o,
    input  wire logic                   fifo_ready_i
);

    logic                   sign_ext;
    logic [63:0]            a_ext;
    logic [63:0]            b_ext;
    logic                   s2_adv;
    logic                   s1_valid_q;
    logic [63:0]            s1_prod_q;
    mdu_pkg::mul_op_e       s1_op_q;
    cpu_types_pkg::rob_id_t s1_dest_q;

    // only the signed high word needs sign extension
    assign sign_ext = (req_i.op == mdu_pkg::MULH_W);
    assign a_ext = sign_ext ? {{32{req_i.data[0][31]}}, req_i.data[0]} : {32'b0, req_i.data[0]};
    assign b_ext = sign_ext ? {{32{req_i.data[1][31]}}, req_i.data[1]} : {32'b0, req_i.data[1]};

    // stall chain from the output FIFO back to stage 1
    assign s2_adv   = !res_valid_o || fifo_ready_i;
    assign accept_o = !s1_valid_q || s2_adv;

    // --------------------
    // stage 1 product
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            s1_valid_q <= 1'b0;
        end else if (accept_o) begin
            s1_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o) begin
            s1_prod_q <= a_ext * b_ext;
            s1_op_q   <= req_i.op;
            s1_dest_q <= req_i.dest;
        end
    end

    // --------------------
    // stage 2 word select
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            res_valid_o <= 1'b0;
        end else if (s2_adv) begin
            res_valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_adv) begin
            res_o.dest <= s1_dest_q;
            res_o.data <= (s1_op_q == mdu_pkg::MUL_W) ? s1_prod_q[31:0] : s1_prod_q[63:32];
        end
    end

endmodule

`default_nettype wire

//--- hdl/mdu_iq_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_macros.svh"

module mdu_iq_top (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n_i,
    input  wire logic                                   flush_i,
    input  wire logic [1:0]                             choose_i,
    input  wire mdu_pkg::dispatch_t [1:0]               dispatch_i,
    output logic                                        entry_ready_o,
    input  wire cpu_types_pkg::cdb_t [`CDB_COUNT-1:0]   cdb_i,
    output mdu_pkg::mul_res_t                           result_o,
    output logic                                        result_valid_o,
    input  wire logic                                   fifo_ready_i
);

    logic [`IQ_SIZE-1:0]                wr_en;
    mdu_pkg::dispatch_t [`IQ_SIZE-1:0]  wr_data;
    logic [`IQ_SIZE-1:0]                entry_rdy;
    mdu_pkg::dispatch_t [`IQ_SIZE-1:0]  entry_data;
    logic [`IQ_SIZE-1:0]                clear;
    logic                               issue;
    mdu_pkg::mul_req_t                  req;
    logic                               req_valid;
    logic                               accept;

    // --------------------
    // allocation
    // --------------------
    iq_alloc u_alloc (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .choose_i      (choose_i),
        .dispatch_i    (dispatch_i),
        .issue_i       (issue),
        .entry_ready_o (entry_ready_o),
        .wr_en_o       (wr_en),
        .wr_data_o     (wr_data)
    );

    // queue storage
    for (genvar i = 0; i < `IQ_SIZE; i++) begin : g_entry
        iq_entry u_entry (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .flush_i   (flush_i),
            .wr_en_i   (wr_en[i]),
            .wr_data_i (wr_data[i]),
            .cdb_i     (cdb_i),
            .clear_i   (clear[i]),
            .ready_o   (entry_rdy[i]),
            .entry_o   (entry_data[i])
        );
    end

    // --------------------
    // issue and execute
    // --------------------
    iq_issue u_issue (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .ready_i     (entry_rdy),
        .entry_i     (entry_data),
        .accept_i    (accept),
        .clear_o     (clear),
        .issue_o     (issue),
        .req_o       (req),
        .req_valid_o (req_valid)
    );

    mul_unit u_mul (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .req_i        (req),
        .req_valid_i  (req_valid),
        .accept_o     (accept),
        .res_o        (result_o),
        .res_valid_o  (result_valid_o),
        .fifo_ready_i (fifo_ready_i)
    );

endmodule

`default_nettype wire

//--- tb/mdu_iq_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mdu_iq_checker (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   flush_i,
    input  wire logic [1:0]             choose_i,
    input  wire logic                   entry_ready_o,
    input  wire mdu_pkg::mul_res_t      result_o,
    input  wire logic                   result_valid_o,
    input  wire logic                   fifo_ready_i
);

    int fail_cnt = 0;

    // a stalled result keeps its tag and data
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
        result_valid_o && !fifo_ready_i && !flush_i |=> result_valid_o && $stable(result_o))
    else begin
        fail_cnt++;
        $error("result_o changed while the result port was stalled");
    end

    no_choose_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        !entry_ready_o |-> choose_i == 2'b00)
    else begin
        fail_cnt++;
        $error("choose_i set while entry_ready_o was low");
    end

    // first cycle out of reset
    idle_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !result_valid_o)
    else begin
        fail_cnt++;
        $error("result_valid_o high right after reset");
    end

endmodule

`default_nettype wire

//--- tb/mdu_iq_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mdu_macros.svh"

module mdu_iq_tb;

    localparam int TIMEOUT = 1000;

    logic                                   clk;
    logic                                   rst_n_i;
    logic                                   flush_i;
    logic [1:0]                             choose_i;
    mdu_pkg::dispatch_t [1:0]               dispatch_i;
    logic                                   entry_ready_o;
    cpu_types_pkg::cdb_t [`CDB_COUNT-1:0]   cdb_i;
    mdu_pkg::mul_res_t                      result_o;
    logic                                   result_valid_o;
    logic                                   fifo_ready_i;

    // expected results in dispatch order
    mdu_pkg::mul_res_t      exp_q[$];
    cpu_types_pkg::word_t   bcast_val [64];
    cpu_types_pkg::rob_id_t next_tag;
    cpu_types_pkg::rob_id_t dest_tag;
    int                     fifo_mode;
    int                     fill_cnt;

    mdu_iq_top dut0 (.*);

    bind mdu_iq_top mdu_iq_checker u_checker (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .choose_i       (choose_i),
        .entry_ready_o  (entry_ready_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .fifo_ready_i   (fifo_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // reference and checks
    // --------------------

    function automatic cpu_types_pkg::word_t ref_mul(mdu_pkg::mul_op_e op,
                                                     cpu_types_pkg::word_t a,
                                                     cpu_types_pkg::word_t b);
        longint      sa;
        longint      sb;
        logic [63:0] prod;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        if (op == mdu_pkg::MULH_W) begin
            prod = sa * sb;
        end else begin
            prod = 64'(a) * 64'(b);
        end
        // low word is the same for signed and unsigned
        return (op == mdu_pkg::MUL_W) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // absent operands take the value that the CDB will broadcast
    function automatic mdu_pkg::mul_res_t expect_of(mdu_pkg::dispatch_t d);
        cpu_types_pkg::word_t v0;
        cpu_types_pkg::word_t v1;
        mdu_pkg::mul_res_t    r;
        v0 = d.src[0].present ? d.src[0].value : bcast_val[d.src[0].tag];
        v1 = d.src[1].present ? d.src[1].value : bcast_val[d.src[1].tag];
        r.dest = d.dest;
        r.data = ref_mul(d.op, v0, v1);
        return r;
    endfunction

    always @(posedge clk) begin : compare_results
        mdu_pkg::mul_res_t exp_r;
        if (rst_n_i && result_valid_o && fifo_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("result with tag %h arrived but none was expected", result_o.dest);
                abort_run();
            end else begin
                exp_r = exp_q.pop_front();
                check_eq("result_o.dest", 64'(result_o.dest), 64'(exp_r.dest));
                check_eq("result_o.data", 64'(result_o.data), 64'(exp_r.data));
            end
        end
    end

    always @(posedge clk) begin
        if (dut0.u_checker.fail_cnt != 0) begin
            $display("a protocol assertion failed in the checker");
            abort_run();
        end
    end

    // 0 always ready, 1 random stalls, 2 held stalled
    always @(posedge clk) begin
        case (fifo_mode)
            0:       fifo_ready_i <= 1'b1;
            1:       fifo_ready_i <= (($urandom % 4) != 0);
            default: fifo_ready_i <= 1'b0;
        endcase
    end

    // --------------------
    // stimulus helpers
    // --------------------

    function automatic cpu_types_pkg::word_t rand_word();
        case ($urandom % 8)
            0:       return 32'hffff_ffff;
            1:       return 32'h8000_0000;
            default: return $urandom;
        endcase
    endfunction

    function automatic cpu_types_pkg::operand_t ready_opnd(cpu_types_pkg::word_t v);
        cpu_types_pkg::operand_t o;
        o.present = 1'b1;
        o.tag     = 6'($urandom);
        o.value   = v;
        return o;
    endfunction

    // stale value differs from the one that will be broadcast
    function automatic cpu_types_pkg::operand_t wait_opnd(cpu_types_pkg::rob_id_t t);
        cpu_types_pkg::operand_t o;
        o.present = 1'b0;
        o.tag     = t;
        o.value   = ~bcast_val[t];
        return o;
    endfunction

    function automatic cpu_types_pkg::rob_id_t new_tag();
        cpu_types_pkg::rob_id_t t;
        t            = next_tag;
        next_tag     = next_tag + 6'd1;
        bcast_val[t] = rand_word();
        return t;
    endfunction

    function automatic mdu_pkg::dispatch_t rand_op();
        mdu_pkg::dispatch_t d;
        d.op     = mdu_pkg::mul_op_e'(2'($urandom % 3));
        d.dest   = dest_tag;
        dest_tag = dest_tag + 6'd1;
        d.src[0] = ready_opnd(rand_word());
        d.src[1] = ready_opnd(rand_word());
        return d;
    endfunction

    // one edge, strobes back to idle
    task automatic tick();
        @(posedge clk);
        choose_i <= 2'b00;
        cdb_i    <= '0;
    endtask

    task automatic try_send(logic [1:0] ch, mdu_pkg::dispatch_t d0, mdu_pkg::dispatch_t d1,
                            output logic sent);
        @(posedge clk);
        sent = entry_ready_o;
        if (sent) begin
            choose_i      <= ch;
            dispatch_i[0] <= d0;
            dispatch_i[1] <= d1;
            if (ch[0]) begin
                exp_q.push_back(expect_of(d0));
            end
            if (ch[1]) begin
                exp_q.push_back(expect_of(d1));
            end
        end
    endtask

    task automatic send(logic [1:0] ch, mdu_pkg::dispatch_t d0, mdu_pkg::dispatch_t d1);
        logic sent;
        int   cnt;
        cnt = 0;
        try_send(ch, d0, d1, sent);
        while (!sent) begin
            if (cnt == TIMEOUT) begin
                $display("timeout waiting for entry_ready_o to dispatch");
                abort_run();
            end
            cnt++;
            try_send(ch, d0, d1, sent);
        end
    endtask

    task automatic bcast(logic port, cpu_types_pkg::rob_id_t t);
        cdb_i[port] <= '{valid: 1'b1, tag: t, data: bcast_val[t]};
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            if (cnt == TIMEOUT) begin
                $display("timeout with %0d results still missing", exp_q.size());
                abort_run();
            end
            cnt++;
            tick();
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin : stimulus
        mdu_pkg::dispatch_t     d0;
        cpu_types_pkg::rob_id_t tag_a;
        cpu_types_pkg::rob_id_t tag_b;
        logic                   sent;
        int                     cnt;

        void'($urandom(32'hd864_f49a));
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        choose_i     = 2'b00;
        dispatch_i   = '0;
        cdb_i        = '0;
        fifo_ready_i = 1'b1;
        fifo_mode    = 0;
        next_tag     = '0;
        dest_tag     = '0;
        fill_cnt     = 0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        tick();
        check_eq("entry_ready_o", 64'(entry_ready_o), 64'd1);

        // each opcode once with a negative operand
        for (int i = 0; i < 3; i++) begin
            d0 = rand_op();
            d0.op = mdu_pkg::mul_op_e'(2'(i));
            d0.src[0].value = 32'hffff_fff6;
            send(2'b01, d0, d0);
            tick();
        end
        // random single, slot 1 alone and dual dispatch
        for (int i = 0; i < 24; i++) begin
            send(2'(1 + $urandom % 3), rand_op(), rand_op());
            tick();
        end
        wait_drain();

        // waiting head blocks two younger ready ops
        d0 = rand_op();
        tag_a = new_tag();
        d0.src[0] = wait_opnd(tag_a);
        send(2'b01, d0, d0);
        tick();
        send(2'b11, rand_op(), rand_op());
        tick();
        repeat (8) tick();
        check_eq("result_valid_o", 64'(result_valid_o), 64'd0);
        bcast(1'b0, tag_a);
        tick();
        wait_drain();

        // same-edge wakeup on both CDB ports
        d0 = rand_op();
        tag_a = new_tag();
        tag_b = new_tag();
        d0.src[0] = wait_opnd(tag_a);
        d0.src[1] = wait_opnd(tag_b);
        send(2'b10, rand_op(), d0);
        bcast(1'b0, tag_a);
        bcast(1'b1, tag_b);
        tick();
        wait_drain();

        // random back-pressure
        fifo_mode <= 1;
        for (int i = 0; i < 30; i++) begin
            send(2'(1 + $urandom % 3), rand_op(), rand_op());
            tick();
        end
        wait_drain();

        // fill with the output held stalled
        fifo_mode <= 2;
        tick();
        tick();
        sent = 1'b1;
        cnt  = 0;
        while (sent) begin
            if (cnt == TIMEOUT) begin
                $display("timeout waiting for entry_ready_o to fall");
                abort_run();
            end
            cnt++;
            try_send(2'b11, rand_op(), rand_op(), sent);
            if (sent) begin
                fill_cnt += 2;
            end
            tick();
        end
        check_eq("entry_ready_o", 64'(entry_ready_o), 64'd0);
        if (fill_cnt < `IQ_SIZE - 1 || fill_cnt > `IQ_SIZE + 3) begin
            $display("entry_ready_o fell after %0d ops, outside the expected range", fill_cnt);
            abort_run();
        end
        fifo_mode <= 0;
        wait_drain();
        tick();
        check_eq("entry_ready_o", 64'(entry_ready_o), 64'd1);

        // flush a full queue with results stalled in the pipe
        fifo_mode <= 2;
        tick();
        for (int i = 0; i < 5; i++) begin
            d0 = rand_op();
            if (i[0]) begin
                d0.src[1] = wait_opnd(new_tag());
            end
            send(2'b11, d0, rand_op());
            tick();
        end
        flush_i <= 1'b1;
        tick();
        // no room left in the flush cycle
        check_eq("entry_ready_o", 64'(entry_ready_o), 64'd0);
        flush_i <= 1'b0;
        exp_q.delete();
        fifo_mode <= 0;
        tick();
        check_eq("entry_ready_o", 64'(entry_ready_o), 64'd1);
        for (int i = 0; i < 12; i++) begin
            tick();
            check_eq("result_valid_o", 64'(result_valid_o), 64'd0);
        end

        // traffic after the flush
        for (int i = 0; i < 10; i++) begin
            send(2'(1 + $urandom % 3), rand_op(), rand_op());
            tick();
        end
        wait_drain();
        tick();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/cpu_types_pkg.sv
hdl/mdu_pkg.sv
hdl/iq_alloc.sv
hdl/iq_entry.sv
hdl/iq_issue.sv
hdl/mul_unit.sv
hdl/mdu_iq_top.sv
tb/mdu_iq_checker.sv
tb/mdu_iq_tb.sv

//--- run.sh
#!/bin/sh
# build and run the issue queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module mdu_iq_tb -o mdu_iq_sim \
    && ./obj_dir/mdu_iq_sim +verilator+error+limit+100 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "Test OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
